// ==== common/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 7;
    localparam int TAG_BITS    = 21;
    localparam int ROW_BITS    = 6;   // row within one bank
    localparam int LINE_BITS   = 128;
    localparam int WORD_BITS   = 64;
    localparam int NUM_BANKS   = 4;

    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [7:0]           strb_t;

    // bus address, seen raw or split into cache fields
    typedef union packed {
        logic [TAG_BITS+INDEX_BITS+OFFSET_BITS-1:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [INDEX_BITS-1:0]  index;
            logic [OFFSET_BITS-1:0] offset;
        } f;
    } line_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,   // read hit in flight
        MISS,     // waiting on refill beats
        REPLACE,  // install or start victim read
        REWAIT,   // victim line coming out of the bank
        REFILL    // write back victim, then install
    } state_t;

endpackage

`default_nettype wire

// ==== dcache_ctrl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128,
    parameter int BEATS    = 2
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           valid,
    input  wire                           op,
    input  wire [TAG_BITS-1:0]            tag,
    input  wire [INDEX_BITS-1:0]          index,
    input  wire [OFFSET_BITS-1:0]         offset,
    output logic                          addr_ok,
    output logic                          data_ok,
    output word_t                         rdata,
    output logic                          busy,
    input  wire line_t                    bit_mask,
    input  wire line_t                    line_wdata,
    output logic                          rd_req,
    output logic [31:0]                   rd_addr,
    input  wire                           rd_rdy,
    input  wire                           ret_valid,
    input  wire                           ret_last,
    input  wire word_t                    ret_data,
    output logic                          wr_req,
    output logic [31:0]                   wr_addr,
    output line_t                         wr_data,
    input  wire                           wr_rdy,
    output logic                          bank_en,
    output logic                          bank_we,
    output logic [$clog2(NUM_BANKS)-1:0]  bank_sel,
    output logic [ROW_BITS-1:0]           row,
    output line_t                         mask,
    output line_t                         wdata,
    input  wire line_t                    bank_rdata
);

    state_t                     state;
    line_addr_u                 req_q;
    logic                       req_op;
    line_t                      req_mask;
    line_t                      req_wdata;
    line_t                      refill_q;
    line_t                      victim_q;
    line_t                      merged;
    line_t                      rd_src;
    logic [$clog2(BEATS)-1:0]   beat;
    logic                       rd_sent;
    logic                       rewait_q;
    logic                       hit_hi;
    logic                       sel_hi;
    logic                       hit;
    logic                       hit_way;
    logic                       victim_way;
    logic                       victim_dirty;
    logic [TAG_BITS-1:0]        victim_tag;
    logic                       accept;
    logic                       install;
    line_addr_u                 rd_line;
    line_addr_u                 wr_line;

    tag_store #(
        .NUM_SETS (NUM_SETS)
    ) u_tags (
        .clk           (clk),
        .rst           (rst),
        .look_index    (index),
        .look_tag      (tag),
        .hit           (hit),
        .hit_way       (hit_way),
        .buf_index     (req_q.f.index),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .install       (install),
        .install_way   (victim_way),
        .install_tag   (req_q.f.tag),
        .install_dirty (req_op),
        .set_dirty     (accept && hit && op),
        .dirty_way     (hit_way)
    );

    assign accept  = valid && (state == IDLE || state == LOOKUP);
    assign install = (state == REPLACE && !victim_dirty) || (state == REFILL && wr_rdy);
    assign rd_req  = state == MISS && rd_rdy && !rd_sent;
    assign wr_req  = state == REFILL && wr_rdy;
    assign wr_data = victim_q;
    assign merged  = req_op ? (refill_q & req_mask) | (req_wdata & ~req_mask) : refill_q;

    // line aligned bus addresses
    always_comb begin
        rd_line.f.tag    = req_q.f.tag;
        rd_line.f.index  = req_q.f.index;
        rd_line.f.offset = '0;
        wr_line.f.tag    = victim_tag;     // victim's own tag
        wr_line.f.index  = req_q.f.index;
        wr_line.f.offset = '0;
    end

    assign rd_addr = rd_line.raw;
    assign wr_addr = wr_line.raw;

    // read miss data comes straight from the refill buffer
    assign rd_src = (state == REPLACE) ? refill_q : bank_rdata;
    assign sel_hi = (state == REPLACE) ? req_q.f.offset[3] : hit_hi;
    assign rdata  = sel_hi ? rd_src[LINE_BITS-1 -: WORD_BITS] : rd_src[WORD_BITS-1:0];

    always_comb begin
        bank_en  = 1'b0;
        bank_we  = 1'b0;
        bank_sel = {hit_way, index[INDEX_BITS-1]};
        row      = index[ROW_BITS-1:0];
        mask     = bit_mask;
        wdata    = line_wdata;
        if (accept && hit) begin
            bank_en = 1'b1;
            bank_we = op;
        end else if (state == REPLACE || install) begin
            bank_en  = 1'b1;
            bank_we  = install;                    // else victim read
            bank_sel = {victim_way, req_q.f.index[INDEX_BITS-1]};
            row      = req_q.f.index[ROW_BITS-1:0];
            mask     = '0;
            wdata    = merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            addr_ok  <= 1'b0;
            data_ok  <= 1'b0;
            busy     <= 1'b0;
            rd_sent  <= 1'b0;
            rewait_q <= 1'b0;
            beat     <= '0;
            hit_hi   <= 1'b0;
        end else begin
            addr_ok <= accept;
            data_ok <= state == LOOKUP || (state == MISS && ret_valid && ret_last && !req_op);
            if (state == LOOKUP) begin
                hit_hi <= req_q.f.offset[3];
            end
            case (state)
                IDLE, LOOKUP: begin
                    rd_sent <= 1'b0;
                    beat    <= '0;
                    if (!accept) begin
                        state <= IDLE;
                    end else if (!hit) begin
                        state <= MISS;
                        busy  <= 1'b1;
                    end else begin
                        state <= op ? IDLE : LOOKUP;   // write hit is done here
                    end
                end
                MISS: begin
                    if (rd_req) begin
                        rd_sent <= 1'b1;
                    end
                    if (ret_valid) begin
                        beat <= beat + 1'b1;
                        if (ret_last) begin
                            state <= REPLACE;
                        end
                    end
                end
                REPLACE: begin
                    if (victim_dirty) begin
                        state <= REWAIT;
                    end else begin
                        state <= IDLE;
                        busy  <= 1'b0;
                    end
                end
                REWAIT: begin
                    rewait_q <= !rewait_q;                // pins, then data
                    if (rewait_q) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (wr_rdy) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.f.tag    <= tag;
            req_q.f.index  <= index;
            req_q.f.offset <= offset;
            req_op         <= op;
            req_mask       <= bit_mask;
            req_wdata      <= line_wdata;
        end
        if (state == MISS && ret_valid) begin
            refill_q[beat*WORD_BITS +: WORD_BITS] <= ret_data;   // low beat first
        end
        if (state == REWAIT && rewait_q) begin
            victim_q <= bank_rdata;
        end
    end

    a_one_bus_req: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req));
    a_idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, LOOKUP} |-> !busy);

endmodule

`default_nettype wire

// ==== dcache_ctrl/tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_store
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [INDEX_BITS-1:0]  look_index,
    input  wire [TAG_BITS-1:0]    look_tag,
    output logic                  hit,
    output logic                  hit_way,
    input  wire [INDEX_BITS-1:0]  buf_index,
    output logic                  victim_way,
    output logic                  victim_dirty,
    output logic [TAG_BITS-1:0]   victim_tag,
    input  wire                   install,
    input  wire                   install_way,
    input  wire [TAG_BITS-1:0]    install_tag,
    input  wire                   install_dirty,
    input  wire                   set_dirty,
    input  wire                   dirty_way
);

    logic [TAG_BITS-1:0] tag_q [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [2];
    logic [NUM_SETS-1:0] dirty_q [2];
    logic [1:0]          way_hit;
    logic                v0;
    logic                v1;
    logic                d0;
    logic                d1;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][look_index] && tag_q[w][look_index] == look_tag;
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    assign v0 = valid_q[0][buf_index];
    assign v1 = valid_q[1][buf_index];
    assign d0 = dirty_q[0][buf_index];
    assign d1 = dirty_q[1][buf_index];

    // empty way first, then a clean one, else way 0 with write-back
    assign victim_way   = v0 && (!v1 || (d0 && !d1));
    assign victim_dirty = valid_q[victim_way][buf_index] && dirty_q[victim_way][buf_index];
    assign victim_tag   = tag_q[victim_way][buf_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
                for (int s = 0; s < NUM_SETS; s++) begin
                    tag_q[w][s] <= '0;
                end
            end
        end else begin
            if (install) begin
                valid_q[install_way][buf_index] <= 1'b1;
                tag_q[install_way][buf_index]   <= install_tag;
                dirty_q[install_way][buf_index] <= install_dirty;   // write miss installs dirty
            end
            if (set_dirty) begin
                dirty_q[dirty_way][look_index] <= 1'b1;
            end
        end
    end

    // a miss must never install a line that the other way still holds
    a_no_dup_tag: assert property (@(posedge clk) disable iff (rst) !(&way_hit));

endmodule

`default_nettype wire

// ==== sources.f ====
common/dcache_pkg.sv
src/req_align.sv
dcache_ctrl/tag_store.sv
dcache_ctrl/dcache_ctrl.sv
src/bank_port.sv
src/dcache_top.sv
verification/tb_clock.sv
verification/tb_models.sv
verification/dcache_tb.sv

// ==== src/bank_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_port
    import dcache_pkg::*;
(
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                bank_en,
    input  wire                                bank_we,
    input  wire [$clog2(NUM_BANKS)-1:0]        bank_sel,
    input  wire [ROW_BITS-1:0]                 row,
    input  wire line_t                         mask,
    input  wire line_t                         wdata,
    output logic [NUM_BANKS-1:0][ROW_BITS-1:0] sram_addr,
    output logic [NUM_BANKS-1:0]               sram_cen,
    output logic [NUM_BANKS-1:0]               sram_wen,
    output line_t [NUM_BANKS-1:0]              sram_wmask,
    output line_t [NUM_BANKS-1:0]              sram_wdata,
    input  wire line_t [NUM_BANKS-1:0]         sram_rdata,
    output line_t                              rdata
);

    logic [$clog2(NUM_BANKS)-1:0] pin_sel;   // bank on the pins now
    logic [$clog2(NUM_BANKS)-1:0] rd_bank;   // bank whose data is out now

    always_ff @(posedge clk) begin
        if (rst) begin
            sram_cen <= '1;
            sram_wen <= '1;
            pin_sel  <= '0;
            rd_bank  <= '0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                sram_cen[b] <= !(bank_en && bank_sel == b);
                sram_wen[b] <= !(bank_en && bank_we && bank_sel == b);
            end
            if (bank_en) begin
                pin_sel <= bank_sel;
            end
            rd_bank <= pin_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (bank_en) begin
            sram_addr[bank_sel]  <= row;
            sram_wmask[bank_sel] <= mask;
            sram_wdata[bank_sel] <= wdata;
        end
    end

    assign rdata = sram_rdata[rd_bank];

    a_one_bank: assert property (@(posedge clk) disable iff (rst) $onehot0(~sram_cen));

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128,
    parameter int BEATS    = 2
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   valid,
    input  wire                                   op,
    input  wire [TAG_BITS-1:0]                    tag,
    input  wire [INDEX_BITS-1:0]                  index,
    input  wire [OFFSET_BITS-1:0]                 offset,
    input  wire strb_t                            wstrb,
    input  wire word_t                            wdata,
    output logic                                  addr_ok,
    output logic                                  data_ok,
    output word_t                                 rdata,
    output logic                                  busy,
    output logic                                  rd_req,
    output logic [31:0]                           rd_addr,
    input  wire                                   rd_rdy,
    input  wire                                   ret_valid,
    input  wire                                   ret_last,
    input  wire word_t                            ret_data,
    output logic                                  wr_req,
    output logic [31:0]                           wr_addr,
    output line_t                                 wr_data,
    input  wire                                   wr_rdy,
    output logic [NUM_BANKS-1:0][ROW_BITS-1:0]    sram_addr,
    output logic [NUM_BANKS-1:0]                  sram_cen,
    output logic [NUM_BANKS-1:0]                  sram_wen,
    output line_t [NUM_BANKS-1:0]                 sram_wmask,
    output line_t [NUM_BANKS-1:0]                 sram_wdata,
    input  wire line_t [NUM_BANKS-1:0]            sram_rdata
);

    line_t                        bit_mask;
    line_t                        line_wdata;
    logic                         bank_en;
    logic                         bank_we;
    logic [$clog2(NUM_BANKS)-1:0] bank_sel;
    logic [ROW_BITS-1:0]          row;
    line_t                        mask;
    line_t                        bank_wdata;
    line_t                        bank_rdata;

    req_align u_req_align (
        .offset     (offset),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .bit_mask   (bit_mask),
        .line_wdata (line_wdata)
    );

    dcache_ctrl #(
        .NUM_SETS (NUM_SETS),
        .BEATS    (BEATS)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .op         (op),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .busy       (busy),
        .bit_mask   (bit_mask),
        .line_wdata (line_wdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_sel   (bank_sel),
        .row        (row),
        .mask       (mask),
        .wdata      (bank_wdata),
        .bank_rdata (bank_rdata)
    );

    bank_port u_bank_port (
        .clk        (clk),
        .rst        (rst),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_sel   (bank_sel),
        .row        (row),
        .mask       (mask),
        .wdata      (bank_wdata),
        .sram_addr  (sram_addr),
        .sram_cen   (sram_cen),
        .sram_wen   (sram_wen),
        .sram_wmask (sram_wmask),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .rdata      (bank_rdata)
    );

endmodule

`default_nettype wire

// ==== src/req_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_align
    import dcache_pkg::*;
(
    input  wire [OFFSET_BITS-1:0] offset,
    input  wire strb_t            wstrb,
    input  wire word_t            wdata,
    output line_t                 bit_mask,    // active low, 0 means write
    output line_t                 line_wdata
);

    word_t      byte_mask;
    word_t      half_mask;
    word_t      half_data;
    logic [5:0] shamt;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            byte_mask[i*8 +: 8] = {8{wstrb[i]}};
        end
    end

    assign shamt     = {offset[2:0], 3'b000};   // byte offset in bits
    assign half_mask = byte_mask << shamt;
    assign half_data = wdata << shamt;

    // top offset bit picks the upper or lower half of the line
    assign bit_mask = offset[3] ? {~half_mask, {WORD_BITS{1'b1}}}
                                : {{WORD_BITS{1'b1}}, ~half_mask};
    assign line_wdata = offset[3] ? {half_data, {WORD_BITS{1'b0}}}
                                  : {{WORD_BITS{1'b0}}, half_data};

endmodule

`default_nettype wire

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_SETS     = 128;
    localparam int BEATS        = 2;
    localparam int NUM_REQS     = 17;   // requests over all tests
    localparam int REQ_CYCLES   = 12;   // dirty miss, worst case
    localparam int LIMIT_CYCLES = NUM_REQS * REQ_CYCLES * 4;

    logic                                  clk;
    logic                                  rst;
    logic                                  valid;
    logic                                  op;
    logic [TAG_BITS-1:0]                   tag;
    logic [INDEX_BITS-1:0]                 index;
    logic [OFFSET_BITS-1:0]                offset;
    strb_t                                 wstrb;
    word_t                                 wdata;
    logic                                  addr_ok;
    logic                                  data_ok;
    word_t                                 rdata;
    logic                                  busy;
    logic                                  rd_req;
    logic [31:0]                           rd_addr;
    logic                                  rd_rdy;
    logic                                  ret_valid;
    logic                                  ret_last;
    word_t                                 ret_data;
    logic                                  wr_req;
    logic [31:0]                           wr_addr;
    line_t                                 wr_data;
    logic                                  wr_rdy;
    logic [NUM_BANKS-1:0][ROW_BITS-1:0]    sram_addr;
    logic [NUM_BANKS-1:0]                  sram_cen;
    logic [NUM_BANKS-1:0]                  sram_wen;
    logic [NUM_BANKS-1:0][LINE_BITS-1:0]   sram_wmask;
    logic [NUM_BANKS-1:0][LINE_BITS-1:0]   sram_wdata;
    wire  [NUM_BANKS-1:0][LINE_BITS-1:0]   sram_rdata;
    integer                                seed;

    tb_clock #(.PERIOD(40), .RESET_CYCLES(2)) u_clock (.clk(clk), .rst(rst));

    dcache_top #(
        .NUM_SETS (NUM_SETS),
        .BEATS    (BEATS)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .op         (op),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .busy       (busy),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy),
        .sram_addr  (sram_addr),
        .sram_cen   (sram_cen),
        .sram_wen   (sram_wen),
        .sram_wmask (sram_wmask),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank u_bank (
            .clk   (clk),
            .cen   (sram_cen[b]),
            .wen   (sram_wen[b]),
            .addr  (sram_addr[b]),
            .wmask (sram_wmask[b]),
            .wdata (sram_wdata[b]),
            .rdata (sram_rdata[b])
        );
    end

    bus_mem u_bus (
        .clk       (clk),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic fail_now();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, got);
            fail_now();
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t got);
        if (got !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, got);
            fail_now();
        end
    endtask

    task automatic check_addr(input string name, input line_addr_u exp, input line_addr_u got);
        if (got.raw !== exp.raw) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp.raw, got.raw);
            fail_now();
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        if (!cond) begin
            $display("%s", what);
            fail_now();
        end
    endtask

    function automatic word_t mem_word(input logic [31:0] a);
        return {~a, a ^ 32'h3c5a_96e1};
    endfunction

    function automatic word_t bus_word(input line_addr_u a);
        return mem_word({a.raw[31:3], 3'b000});   // word holding the offset
    endfunction

    // strobed bytes of d land sh bytes up within the word
    function automatic word_t merge_word(input word_t old, input logic [2:0] sh,
                                         input strb_t s, input word_t d);
        word_t w;
        w = old;
        for (int i = 0; i + sh < 8; i++) begin
            if (s[i]) begin
                w[(i + sh) * 8 +: 8] = d[i * 8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic line_addr_u make_addr(input logic [TAG_BITS-1:0] t,
                                             input logic [INDEX_BITS-1:0] x,
                                             input logic [OFFSET_BITS-1:0] o);
        line_addr_u a;
        a.f.tag    = t;
        a.f.index  = x;
        a.f.offset = o;
        return a;
    endfunction

    task automatic drive_req(input logic wr, input line_addr_u a, input strb_t s, input word_t d);
        valid  = 1'b1;
        op     = wr;
        tag    = a.f.tag;
        index  = a.f.index;
        offset = a.f.offset;
        wstrb  = s;
        wdata  = d;
    endtask

    // returns in the cycle after acceptance
    task automatic send(input logic wr, input line_addr_u a, input strb_t s, input word_t d);
        drive_req(wr, a, s, d);
        tick();
        while (!addr_ok) begin
            tick();
        end
        valid = 1'b0;
    endtask

    task automatic read_word(input string name, input line_addr_u a, input word_t exp,
                             input bit hit);
        int cycles;
        int reads;
        reads = u_bus.rd_count;
        send(1'b0, a, 8'h00, '0);
        if (hit) begin
            expect_true(!busy, "busy rose on a read hit");
        end else begin
            expect_true(busy, "busy did not rise in the cycle after a read miss");
        end
        cycles = 1;
        while (!data_ok) begin
            tick();
            cycles++;
        end
        check_word(name, exp, rdata);
        if (hit) begin
            expect_true(cycles == 2, "read hit data_ok not two cycles after acceptance");
            expect_true(u_bus.rd_count == reads, "read hit issued a bus read");
        end
        while (busy) begin
            tick();
        end
    endtask

    task automatic write_word(input line_addr_u a, input strb_t s, input word_t d);
        send(1'b1, a, s, d);
        while (busy) begin
            expect_true(!data_ok, "data_ok pulsed during a write miss");
            tick();
        end
        tick();
        expect_true(!data_ok, "data_ok pulsed after a write");
    endtask

    // second read accepted while the first is in LOOKUP
    task automatic read_pair(input string name, input line_addr_u a, input line_addr_u b,
                             input word_t exp_a, input word_t exp_b);
        send(1'b0, a, 8'h00, '0);
        drive_req(1'b0, b, 8'h00, '0);
        tick();
        expect_true(addr_ok && data_ok, "back-to-back read was not overlapped");
        valid = 1'b0;
        check_word({name, " first"}, exp_a, rdata);
        tick();
        expect_true(data_ok, "second back-to-back read gave no data_ok");
        check_word({name, " second"}, exp_b, rdata);
    endtask

    task automatic test_cold_miss();
        line_addr_u a;
        a = make_addr(21'h01234, 7'h05, 4'h8);
        read_word("cold_miss", a, bus_word(a), 1'b0);
        expect_true(u_bus.rd_count == 1, "cold miss did not issue exactly one bus read");
        check_addr("cold_miss rd_addr", make_addr(a.f.tag, a.f.index, 4'h0), u_bus.last_rd_addr);
    endtask

    task automatic test_read_hit();
        line_addr_u lo;
        line_addr_u hi;
        lo = make_addr(21'h01234, 7'h05, 4'h0);
        hi = make_addr(21'h01234, 7'h05, 4'h8);
        read_word("hit_hi", hi, bus_word(hi), 1'b1);
        read_word("hit_lo", lo, bus_word(lo), 1'b1);
        read_pair("hit_pair", lo, hi, bus_word(lo), bus_word(hi));
    endtask

    task automatic test_write_hit();
        line_addr_u lo;
        line_addr_u hi;
        word_t      d;
        lo = make_addr(21'h01234, 7'h05, 4'h0);
        hi = make_addr(21'h01234, 7'h05, 4'h8);
        d = {$random(seed), $random(seed)};
        write_word(hi, 8'ha5, d);
        read_word("write_hit", hi, merge_word(bus_word(hi), 3'd0, 8'ha5, d), 1'b1);
        d = {$random(seed), $random(seed)};
        write_word(make_addr(21'h01234, 7'h05, 4'h4), 8'h0f, d);   // upper four bytes
        read_word("write_hit_off4", lo, merge_word(bus_word(lo), 3'd4, 8'h0f, d), 1'b1);
    endtask

    task automatic test_write_miss();
        line_addr_u lo;
        line_addr_u hi;
        word_t      d;
        lo = make_addr(21'h0abcd, 7'h46, 4'h0);
        hi = make_addr(21'h0abcd, 7'h46, 4'h8);
        d = {$random(seed), $random(seed)};
        write_word(lo, 8'h3c, d);
        read_word("write_miss_lo", lo, merge_word(bus_word(lo), 3'd0, 8'h3c, d), 1'b1);
        read_word("write_miss_hi", hi, bus_word(hi), 1'b1);
        expect_true(u_bus.wr_count == 0, "write-back issued without a dirty victim");
    endtask

    task automatic test_eviction();
        line_addr_u a0;
        line_addr_u a2;
        line_addr_u a3;
        word_t      d0;
        word_t      d1;
        int         writes;
        a0 = make_addr(21'h10001, 7'h2a, 4'h0);
        a2 = make_addr(21'h10003, 7'h2a, 4'h8);
        a3 = make_addr(21'h10004, 7'h2a, 4'h0);
        d0 = {$random(seed), $random(seed)};
        d1 = {$random(seed), $random(seed)};
        write_word(a0, 8'hff, d0);                                   // way 0, dirty
        write_word(make_addr(21'h10002, 7'h2a, 4'h8), 8'hff, d1);   // way 1, dirty
        writes = u_bus.wr_count;
        read_word("evict_miss", a2, bus_word(a2), 1'b0);
        expect_true(u_bus.wr_count == writes + 1, "dirty victim not written back once");
        check_addr("evict wr_addr", a0, u_bus.last_wr_addr);
        check_line("evict wr_data", {mem_word(a0.raw + 32'd8), d0}, u_bus.last_wr_data);
        read_word("evict_keep", make_addr(21'h10002, 7'h2a, 4'h8), d1, 1'b1);
        read_word("clean_victim", a3, bus_word(a3), 1'b0);
        expect_true(u_bus.wr_count == writes + 1, "clean victim caused a write-back");
    endtask

    initial begin
        seed   = 32'hd1c01328;
        valid  = 1'b0;
        op     = 1'b0;
        tag    = '0;
        index  = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        rd_rdy = 1'b1;
        wr_rdy = 1'b1;
        wait (rst === 1'b0);
        tick();
        test_cold_miss();
        test_read_hit();
        test_write_hit();
        test_write_miss();
        test_eviction();
        $display("Test OK");
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        fail_now();
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0;   // released off the edge
    end

endmodule

`default_nettype wire

// ==== verification/tb_models.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank
    import dcache_pkg::*;
(
    input  wire                clk,
    input  wire                cen,
    input  wire                wen,
    input  wire [ROW_BITS-1:0] addr,
    input  wire line_t         wmask,
    input  wire line_t         wdata,
    output line_t              rdata
);

    line_t mem [1 << ROW_BITS];

    initial begin
        rdata = '0;
    end

    always @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= (mem[addr] & wmask) | (wdata & ~wmask);   // mask bit low writes
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

module bus_mem
    import dcache_pkg::*;
(
    input  wire        clk,
    input  wire        rd_req,
    input  wire [31:0] rd_addr,
    output logic       ret_valid,
    output logic       ret_last,
    output word_t      ret_data,
    input  wire        wr_req,
    input  wire [31:0] wr_addr,
    input  wire line_t wr_data
);

    line_t      beats;
    line_addr_u last_rd_addr;
    line_addr_u last_wr_addr;
    line_t      last_wr_data;
    int         rd_count = 0;
    int         wr_count = 0;

    // each 64-bit word is a function of its own byte address
    function automatic word_t pattern_word(input logic [31:0] a);
        return {~a, a ^ 32'h3c5a_96e1};
    endfunction

    initial begin
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
    end

    always begin
        @(posedge clk);
        if (rd_req) begin
            last_rd_addr = rd_addr;
            rd_count++;
            beats = {pattern_word(rd_addr + 32'd8), pattern_word(rd_addr)};
            #2;
            ret_valid = 1'b1;
            ret_last  = 1'b0;
            ret_data  = beats[63:0];   // low beat first
            @(posedge clk);
            #2;
            ret_last  = 1'b1;
            ret_data  = beats[127:64];
            @(posedge clk);
            #2;
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (wr_req) begin
            last_wr_addr = wr_addr;
            last_wr_data = wr_data;
            wr_count++;
        end
    end

endmodule

`default_nettype wire
